// ==== logic/alu_pkg.sv ====
package alu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int word_width      = 32;           // Datapath width
    localparam int reg_addr_width  = 5;            // Register index width
    localparam int imm_width       = 16;           // Immediate field width
    localparam int op_width        = 4;            // Operation code width
    localparam int instr_width     = 36;           // Full instruction width
    localparam int num_regs        = 32;           // Register file depth
    localparam int num_cla_blocks  = 8;            // 4-bit blocks per adder
    localparam int cla_block_width = 4;            // Bits per look-ahead block
    localparam int exec_latency    = 2;            // Issue to writeback edges

    ////////////////////////////////////////////////////////////////////////////
    // Instruction field positions
    ////////////////////////////////////////////////////////////////////////////

    // Layout from the top: op, imm_sel, rd, rs, rt, imm
    localparam int op_lsb      = 32;               // op in [35:32]
    localparam int imm_sel_pos = 31;               // Register or immediate B
    localparam int rd_lsb      = 26;               // rd in [30:26]
    localparam int rs_lsb      = 21;               // rs in [25:21]
    localparam int rt_lsb      = 16;               // rt in [20:16]
    localparam int imm_lsb     = 0;                // imm in [15:0]

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [word_width-1:0]     word_t;        // Data word
    typedef logic [reg_addr_width-1:0] reg_addr_t;    // Register index
    typedef logic [imm_width-1:0]      imm_t;         // Raw immediate
    typedef logic [instr_width-1:0]    instr_word_t;  // Packed instruction

    // Codes 10 to 15 have no name and give a zero result
    typedef enum logic [op_width-1:0] {
        op_add    = 4'd0,                          // A + B
        op_comp   = 4'd1,                          // Two's complement of B
        op_and    = 4'd2,                          // A & B
        op_xor    = 4'd3,                          // A ^ B
        op_sll    = 4'd4,                          // Logical left shift
        op_srl    = 4'd5,                          // Logical right shift
        op_sra    = 4'd6,                          // Arithmetic right shift
        op_pass_a = 4'd7,                          // Forward A
        op_pass_b = 4'd8,                          // Forward B
        op_offset = 4'd9                           // A + zero-extended B[15:0]
    } alu_op_t;

endpackage

// ==== logic/exec_bus_if.sv ====
`timescale 1ns/1ps

interface exec_bus_if;

    logic               valid;                     // Execute stage holds an instruction
    alu_pkg::alu_op_t   op;                        // Operation to run
    alu_pkg::reg_addr_t rd;                        // Destination register
    alu_pkg::word_t     a;                         // Operand A from rs
    alu_pkg::word_t     b;                         // Operand B, rt or immediate
    logic               b_is_imm;                  // B came from the immediate

    // Decode stage drives the bus
    modport decode (
        output valid,
        output op,
        output rd,
        output a,
        output b,
        output b_is_imm
    );

    // Execute stage only reads it
    modport execute (
        input valid,
        input op,
        input rd,
        input a,
        input b,
        input b_is_imm
    );

endinterface

// ==== logic/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic               clk,
    input  logic               rst_n,
    input  alu_pkg::reg_addr_t rs_addr,
    input  alu_pkg::reg_addr_t rt_addr,
    output alu_pkg::word_t     rs_data,
    output alu_pkg::word_t     rt_data,
    input  logic               wr_en,
    input  alu_pkg::reg_addr_t wr_addr,
    input  alu_pkg::word_t     wr_data
);

    alu_pkg::word_t regs [1:alu_pkg::num_regs-1];  // Register 0 has no storage

    logic wr_active;                               // Write that really lands

    assign wr_active = wr_en && (wr_addr != '0);   // Writes to r0 are dropped

    ////////////////////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < alu_pkg::num_regs; i++) begin
                regs[i] <= '0;                     // All registers start at zero
            end
        end else if (wr_active) begin
            regs[wr_addr] <= wr_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////////////////////

    // Shared by both ports
    function automatic alu_pkg::word_t read_port(input alu_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;                             // r0 reads zero
        end
        if (wr_active && (wr_addr == addr)) begin
            return wr_data;                        // Bypass the write in flight
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);              // Port A
        rt_data = read_port(rt_addr);              // Port B
    end

endmodule

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 instr_valid,
    input  alu_pkg::instr_word_t instr,
    output alu_pkg::reg_addr_t   rs_addr,
    output alu_pkg::reg_addr_t   rt_addr,
    input  alu_pkg::word_t       rs_data,
    input  alu_pkg::word_t       rt_data,
    exec_bus_if.decode           exe
);

    alu_pkg::alu_op_t   op_field;                  // Decoded operation
    logic               imm_sel;                   // B from immediate
    alu_pkg::reg_addr_t rd_field;                  // Destination
    alu_pkg::imm_t      imm_field;                 // Raw 16-bit immediate
    alu_pkg::word_t     imm_ext;                   // Sign-extended immediate
    alu_pkg::word_t     b_sel;                     // Chosen B operand

    ////////////////////////////////////////////////////////////////////////////
    // Field extraction
    ////////////////////////////////////////////////////////////////////////////

    assign op_field  = alu_pkg::alu_op_t'(instr[alu_pkg::op_lsb +: alu_pkg::op_width]);
    assign imm_sel   = instr[alu_pkg::imm_sel_pos];
    assign rd_field  = instr[alu_pkg::rd_lsb +: alu_pkg::reg_addr_width];
    assign rs_addr   = instr[alu_pkg::rs_lsb +: alu_pkg::reg_addr_width];  // To register file
    assign rt_addr   = instr[alu_pkg::rt_lsb +: alu_pkg::reg_addr_width];  // To register file
    assign imm_field = instr[alu_pkg::imm_lsb +: alu_pkg::imm_width];

    // Copy imm[15] into the upper half
    assign imm_ext = {{(alu_pkg::word_width - alu_pkg::imm_width){imm_field[alu_pkg::imm_width-1]}},
                      imm_field};

    assign b_sel = imm_sel ? imm_ext : rt_data;    // Immediate or register B

    ////////////////////////////////////////////////////////////////////////////
    // Decode to execute register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exe.valid <= 1'b0;
        end else begin
            exe.valid <= instr_valid;              // One strobe per instruction
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin                     // Payload only moves with a strobe
            exe.op       <= op_field;
            exe.rd       <= rd_field;
            exe.a        <= rs_data;
            exe.b        <= b_sel;
            exe.b_is_imm <= imm_sel;
        end
    end

endmodule

// ==== logic/cla_block_4bit.sv ====
`timescale 1ns/1ps

module cla_block_4bit (
    input  logic [alu_pkg::cla_block_width-1:0] a,
    input  logic [alu_pkg::cla_block_width-1:0] b,
    input  logic                                carry_in,
    output logic [alu_pkg::cla_block_width-1:0] sum,
    output logic                                group_generate,
    output logic                                group_propagate
);

    logic [alu_pkg::cla_block_width-1:0] g;        // Bit generate
    logic [alu_pkg::cla_block_width-1:0] p;        // Bit propagate
    logic [alu_pkg::cla_block_width-1:0] c;        // Carry into each bit

    assign g = a & b;
    assign p = a ^ b;

    // Carries expanded so none waits on the one below
    assign c[0] = carry_in;
    assign c[1] = g[0] | (p[0] & carry_in);
    assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & carry_in);
    assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
                | (p[2] & p[1] & p[0] & carry_in);

    assign sum = p ^ c;

    // Group terms for the upper look-ahead level
    assign group_generate  = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
                           | (p[3] & p[2] & p[1] & g[0]);
    assign group_propagate = &p;                   // Carry passes the whole block

endmodule

// ==== logic/carry_look_ahead_32bit.sv ====
`timescale 1ns/1ps

module carry_look_ahead_32bit (
    input  alu_pkg::word_t a,
    input  alu_pkg::word_t b,
    input  logic           carry_in,
    output alu_pkg::word_t sum,
    output logic           carry_out
);

    localparam int n = alu_pkg::num_cla_blocks;    // Blocks in the chain
    localparam int w = alu_pkg::cla_block_width;   // Bits per block

    logic [n-1:0] group_generate;                  // Per-block generate
    logic [n-1:0] group_propagate;                 // Per-block propagate
    logic [n:0]   block_carry;                     // Carry into each block, top is carry out

    ////////////////////////////////////////////////////////////////////////////
    // First level of look-ahead
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < n; i++) begin : g_block
        cla_block_4bit cla_block_i (
            .a               (a[i*w +: w]),
            .b               (b[i*w +: w]),
            .carry_in        (block_carry[i]),
            .sum             (sum[i*w +: w]),
            .group_generate  (group_generate[i]),
            .group_propagate (group_propagate[i])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Second level of look-ahead
    ////////////////////////////////////////////////////////////////////////////

    // Each block carry is a sum of products over the blocks below it
    always_comb begin
        logic acc;                                 // OR of generate terms so far
        logic prop;                                // AND of propagates above term
        block_carry[0] = carry_in;
        for (int j = 1; j <= n; j++) begin
            acc  = 1'b0;
            prop = 1'b1;
            for (int k = j - 1; k >= 0; k--) begin
                acc  = acc | (prop & group_generate[k]);   // Block k generates, rest pass
                prop = prop & group_propagate[k];
            end
            block_carry[j] = acc | (prop & carry_in);      // Input carry runs all the way
        end
    end

    assign carry_out = block_carry[n];             // 33rd bit of the sum

endmodule

// ==== logic/arithmetic_logic_unit.sv ====
`timescale 1ns/1ps

module arithmetic_logic_unit (
    exec_bus_if.execute    exe,
    output alu_pkg::word_t result,
    output logic           carry,
    output logic           carry_update
);

    localparam int shamt_width = 5;                // Shift amount from B[4:0]

    logic                   is_comp;               // Complement selected
    alu_pkg::word_t         add_a;                 // First adder operand A
    alu_pkg::word_t         add_b;                 // First adder operand B
    alu_pkg::word_t         add_sum;               // First adder result
    logic                   add_carry;             // First adder carry out
    alu_pkg::word_t         offset_b;              // Zero-extended low half of B
    alu_pkg::word_t         offset_sum;            // Offset adder result
    logic [shamt_width-1:0] shamt;                 // Shift amount

    ////////////////////////////////////////////////////////////////////////////
    // Operand selection
    ////////////////////////////////////////////////////////////////////////////

    assign is_comp = (exe.op == alu_pkg::op_comp);

    // Complement computes ~B + 1 on the same adder
    assign add_a = is_comp ? ~exe.b : exe.a;
    assign add_b = is_comp ? alu_pkg::word_t'(1) : exe.b;

    assign offset_b = {{(alu_pkg::word_width - alu_pkg::imm_width){1'b0}},
                       exe.b[alu_pkg::imm_width-1:0]};   // Upper half forced to zero

    assign shamt = exe.b[shamt_width-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Adders
    ////////////////////////////////////////////////////////////////////////////

    carry_look_ahead_32bit add_cla_i (             // Add and complement
        .a         (add_a),
        .b         (add_b),
        .carry_in  (1'b0),
        .sum       (add_sum),
        .carry_out (add_carry)
    );

    carry_look_ahead_32bit offset_cla_i (          // Address offset
        .a         (exe.a),
        .b         (offset_b),
        .carry_in  (1'b0),
        .sum       (offset_sum),
        .carry_out ()                              // Offset never moves the carry flag
    );

    ////////////////////////////////////////////////////////////////////////////
    // Result selection
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (exe.op)
            alu_pkg::op_add,
            alu_pkg::op_comp:   result = add_sum;
            alu_pkg::op_and:    result = exe.a & exe.b;
            alu_pkg::op_xor:    result = exe.a ^ exe.b;
            alu_pkg::op_sll:    result = exe.a << shamt;
            alu_pkg::op_srl:    result = exe.a >> shamt;
            alu_pkg::op_sra:    result = alu_pkg::word_t'($signed(exe.a) >>> shamt);
            alu_pkg::op_pass_a: result = exe.a;
            alu_pkg::op_pass_b: result = exe.b;
            alu_pkg::op_offset: result = offset_sum;
            default:            result = '0;       // Unnamed codes
        endcase
    end

    // Only the arithmetic ops move the carry flag
    assign carry_update = (exe.op == alu_pkg::op_add) || is_comp;

    // Carry comes from the first adder only
    assign carry = add_carry;

endmodule

// ==== logic/alu_datapath.sv ====
`timescale 1ns/1ps

module alu_datapath (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 instr_valid,
    input  alu_pkg::instr_word_t instr,
    output logic                 wb_valid,
    output alu_pkg::reg_addr_t   wb_reg,
    output alu_pkg::word_t       wb_data,
    output logic                 carry_flag,
    output logic                 zero_flag,
    output logic                 sign_flag
);

    alu_pkg::reg_addr_t rs_addr;                   // Decoder read address A
    alu_pkg::reg_addr_t rt_addr;                   // Decoder read address B
    alu_pkg::word_t     rs_data;                   // Register value A
    alu_pkg::word_t     rt_data;                   // Register value B
    alu_pkg::word_t     alu_result;                // Execute stage result
    logic               alu_carry;                 // Carry out of the ALU
    logic               alu_carry_update;          // Op is add or complement

    exec_bus_if exe_bus ();                        // Decode to execute

    ////////////////////////////////////////////////////////////////////////////
    // Stages
    ////////////////////////////////////////////////////////////////////////////

    register_file register_file_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (exe_bus.valid),                  // Write back from execute
        .wr_addr (exe_bus.rd),
        .wr_data (alu_result)                      // Also feeds the bypass
    );

    instr_decoder instr_decoder_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .exe         (exe_bus.decode)
    );

    arithmetic_logic_unit arithmetic_logic_unit_i (
        .exe          (exe_bus.execute),
        .result       (alu_result),
        .carry        (alu_carry),
        .carry_update (alu_carry_update)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Writeback and flags
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid   <= 1'b0;
            wb_reg     <= '0;
            wb_data    <= '0;
            carry_flag <= 1'b0;
            zero_flag  <= 1'b0;
            sign_flag  <= 1'b0;
        end else begin
            wb_valid <= exe_bus.valid;             // Second edge after issue
            if (exe_bus.valid) begin
                wb_reg    <= exe_bus.rd;
                wb_data   <= alu_result;
                zero_flag <= (alu_result == '0);
                sign_flag <= alu_result[alu_pkg::word_width-1];
                if (alu_carry_update) begin
                    carry_flag <= alu_carry;       // Held through other ops
                end
            end
        end
    end

endmodule

// ==== verification/alu_datapath_properties.sv ====
`timescale 1ns/1ps

module alu_datapath_properties (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 instr_valid,
    input alu_pkg::instr_word_t instr,
    input logic                 wb_valid,
    input alu_pkg::word_t       wb_data,
    input logic                 carry_flag,
    input logic                 zero_flag,
    input logic                 sign_flag
);

    int unsigned failures = 0;                     // Polled by the testbench

    logic [alu_pkg::op_width-1:0] issued_op;       // Op field of the issued instruction
    logic                         issued_arith;    // Issued op is add or complement

    assign issued_op    = instr[alu_pkg::op_lsb +: alu_pkg::op_width];
    assign issued_arith = (issued_op == alu_pkg::op_add) || (issued_op == alu_pkg::op_comp);

    ////////////////////////////////////////////////////////////////////////////
    // Writeback timing
    ////////////////////////////////////////////////////////////////////////////

    // Issue at E0, writeback strobe seen at E0 plus exec_latency
    assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid |-> ##(alu_pkg::exec_latency) wb_valid)
    else begin
        $error("Writeback strobe missing two edges after issue");
        failures++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> $past(instr_valid, alu_pkg::exec_latency))
    else begin
        $error("Writeback strobe without a matching issue");
        failures++;
    end

    assert property (@(posedge clk) !rst_n |=> !wb_valid)   // Quiet while in reset
    else begin
        $error("Writeback strobe raised during reset");
        failures++;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Flags
    ////////////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> (zero_flag == (wb_data == '0)) && (sign_flag == wb_data[31]))
    else begin
        $error("Zero or sign flag disagrees with writeback data");
        failures++;
    end

    // Logic, shift and pass ops leave carry alone across their writeback
    assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid && !issued_arith |-> ##(alu_pkg::exec_latency) $stable(carry_flag))
    else begin
        $error("Carry flag moved on a non-arithmetic op");
        failures++;
    end

endmodule

bind alu_datapath alu_datapath_properties alu_datapath_properties_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .wb_valid     (wb_valid),
    .wb_data      (wb_data),
    .carry_flag   (carry_flag),
    .zero_flag    (zero_flag),
    .sign_flag    (sign_flag)
);

// ==== verification/alu_datapath_tb.sv ====
`timescale 1ns/1ps

module alu_datapath_tb;

    localparam int num_directed = 24;              // Hand-picked instructions
    localparam int num_random   = 200;             // LFSR instructions
    localparam int num_instr    = num_directed + num_random;

    typedef struct packed {
        alu_pkg::reg_addr_t rd;
        alu_pkg::word_t     data;
        logic               carry;
    } wb_entry_t;                                  // One expected writeback

    logic clk = 1'b0;
    logic rst_n;
    logic instr_valid;
    alu_pkg::instr_word_t instr;
    logic wb_valid;
    alu_pkg::reg_addr_t wb_reg;
    alu_pkg::word_t wb_data;
    logic carry_flag;
    logic zero_flag;
    logic sign_flag;

    alu_pkg::word_t ref_regs [alu_pkg::num_regs];  // Reference register file
    logic           ref_carry = 1'b0;              // Reference carry flag
    wb_entry_t      expected [$];                  // Writebacks in issue order
    wb_entry_t      head;
    logic [15:0]    lfsr_state = 16'd22746;

    always #10 clk = ~clk;                         // 20 ns period

    alu_datapath alu_datapath_i (.*);

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // x^16+x^14+x^13+x^11+1
    endfunction

    function automatic alu_pkg::word_t rand_bits(input int n);
        alu_pkg::word_t bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr_state[0]};    // One step per bit
            lfsr_state = lfsr_step(lfsr_state);
        end
        return bits;
    endfunction

    function automatic alu_pkg::word_t model_result(input logic [3:0] op,
                                                    input alu_pkg::word_t a,
                                                    input alu_pkg::word_t b);
        case (op)
            alu_pkg::op_add:    return a + b;
            alu_pkg::op_comp:   return -b;
            alu_pkg::op_and:    return a & b;
            alu_pkg::op_xor:    return a ^ b;
            alu_pkg::op_sll:    return a << b[4:0];
            alu_pkg::op_srl:    return a >> b[4:0];
            alu_pkg::op_sra:    return $signed(a) >>> b[4:0];
            alu_pkg::op_pass_a: return a;
            alu_pkg::op_pass_b: return b;
            alu_pkg::op_offset: return a + {16'h0000, b[15:0]};
            default:            return '0;         // Codes 10 to 15
        endcase
    endfunction

    // Model updates in program order, so dependent issues see fresh values
    task automatic issue(input logic [3:0] op, input logic imm_sel, input alu_pkg::reg_addr_t rd,
                         input alu_pkg::reg_addr_t rs, input alu_pkg::reg_addr_t rt,
                         input alu_pkg::imm_t imm);
        alu_pkg::word_t a;
        alu_pkg::word_t b;
        logic [32:0]    wide;
        wb_entry_t      entry;
        a = ref_regs[rs];
        b = imm_sel ? {{16{imm[15]}}, imm} : ref_regs[rt];
        if (op == alu_pkg::op_add) begin
            wide = {1'b0, a} + {1'b0, b};
            ref_carry = wide[32];
        end else if (op == alu_pkg::op_comp) begin
            wide = {1'b0, ~b} + 33'd1;             // Carry of inverted B plus 1
            ref_carry = wide[32];
        end
        entry.rd    = rd;
        entry.data  = model_result(op, a, b);
        entry.carry = ref_carry;
        expected.push_back(entry);
        if (rd != '0) begin
            ref_regs[rd] = entry.data;
        end
        instr_valid = 1'b1;
        instr       = {op, imm_sel, rd, rs, rt, imm};
        @(posedge clk);
        #2;
    endtask

    task automatic report_mismatch(input string field, input alu_pkg::word_t got,
                                   input alu_pkg::word_t exp);
        $display("MISMATCH at %0t: %s got %h expected %h", $time, field, got, exp);
        $display("SOME TESTS FAILED");
        $fatal(1, "%s mismatch", field);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Writeback checker
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin                    // Outputs settled mid-cycle
        if (alu_datapath_i.alu_datapath_properties_i.failures != 0) begin
            $display("ERROR at %0t: a bound property on the datapath failed", $time);
            $display("SOME TESTS FAILED");
            $fatal(1, "bound property failure");
        end else if (rst_n && wb_valid) begin
            if (expected.size() == 0) begin
                $display("ERROR at %0t: writeback with no instruction outstanding", $time);
                $display("SOME TESTS FAILED");
                $fatal(1, "unexpected writeback");
            end else begin
                head = expected.pop_front();
                assert (wb_reg == head.rd) else report_mismatch("wb_reg", wb_reg, head.rd);
                assert (wb_data == head.data) else report_mismatch("wb_data", wb_data, head.data);
                assert (carry_flag == head.carry)
                    else report_mismatch("carry_flag", carry_flag, head.carry);
                assert (zero_flag == (head.data == '0))
                    else report_mismatch("zero_flag", zero_flag, head.data == '0);
                assert (sign_flag == head.data[31])
                    else report_mismatch("sign_flag", sign_flag, head.data[31]);
            end
        end
    end

    initial begin                                  // Watchdog
        #((num_instr + 20) * 20);
        $display("ERROR: timeout, writebacks did not complete in time");
        $display("SOME TESTS FAILED");
        $fatal(1, "timeout");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        alu_pkg::word_t r_op;
        alu_pkg::word_t r_sel;
        alu_pkg::word_t r_rd;
        alu_pkg::word_t r_rs;
        alu_pkg::word_t r_rt;
        alu_pkg::word_t r_imm;
        for (int i = 0; i < alu_pkg::num_regs; i++) begin
            ref_regs[i] = '0;
        end
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        issue(alu_pkg::op_pass_b, 1'b1, 5'd1,  5'd0,  5'd0,  16'h8001);  // Negative constant
        issue(alu_pkg::op_pass_b, 1'b1, 5'd2,  5'd0,  5'd0,  16'h1234);
        issue(alu_pkg::op_pass_b, 1'b1, 5'd0,  5'd0,  5'd0,  16'h5555);  // Dropped
        issue(alu_pkg::op_pass_a, 1'b0, 5'd3,  5'd0,  5'd0,  16'h0000);  // r0 still zero
        issue(alu_pkg::op_add,    1'b0, 5'd4,  5'd1,  5'd1,  16'h0000);  // Carry set
        issue(alu_pkg::op_and,    1'b0, 5'd5,  5'd1,  5'd2,  16'h0000);
        issue(alu_pkg::op_xor,    1'b0, 5'd6,  5'd1,  5'd2,  16'h0000);
        issue(alu_pkg::op_comp,   1'b0, 5'd7,  5'd0,  5'd2,  16'h0000);  // Carry clear
        issue(alu_pkg::op_comp,   1'b1, 5'd8,  5'd0,  5'd0,  16'h0000);  // Zero, carry set
        issue(alu_pkg::op_pass_a, 1'b0, 5'd9,  5'd2,  5'd0,  16'h0000);
        issue(alu_pkg::op_add,    1'b1, 5'd10, 5'd2,  5'd0,  16'h0001);
        issue(alu_pkg::op_sll,    1'b1, 5'd11, 5'd1,  5'd0,  16'h0004);
        issue(alu_pkg::op_srl,    1'b1, 5'd12, 5'd1,  5'd0,  16'h001F);
        issue(alu_pkg::op_sra,    1'b1, 5'd13, 5'd1,  5'd0,  16'hFFE8);  // Only low 5 bits
        issue(alu_pkg::op_pass_b, 1'b0, 5'd14, 5'd0,  5'd2,  16'h0000);
        issue(4'd10,              1'b0, 5'd15, 5'd1,  5'd2,  16'h0000);  // Unnamed codes
        issue(4'd15,              1'b0, 5'd15, 5'd1,  5'd2,  16'h0000);
        issue(alu_pkg::op_offset, 1'b0, 5'd16, 5'd2,  5'd1,  16'h0000);  // Negative B
        issue(alu_pkg::op_offset, 1'b1, 5'd17, 5'd1,  5'd0,  16'hFFF0);
        issue(alu_pkg::op_add,    1'b1, 5'd18, 5'd2,  5'd0,  16'h0001);  // Dependent chain
        issue(alu_pkg::op_add,    1'b1, 5'd18, 5'd18, 5'd0,  16'h0001);
        issue(alu_pkg::op_add,    1'b0, 5'd19, 5'd18, 5'd18, 16'h0000);
        issue(alu_pkg::op_xor,    1'b0, 5'd20, 5'd19, 5'd18, 16'h0000);
        issue(alu_pkg::op_sra,    1'b0, 5'd21, 5'd20, 5'd19, 16'h0000);
        for (int n = 0; n < num_random; n++) begin
            r_op  = rand_bits(4);
            r_sel = rand_bits(1);
            r_rd  = rand_bits(5);
            r_rs  = rand_bits(5);
            r_rt  = rand_bits(5);
            r_imm = rand_bits(16);
            issue(r_op[3:0], r_sel[0], r_rd[4:0], r_rs[4:0], r_rt[4:0], r_imm[15:0]);
        end
        instr_valid = 1'b0;
        while (expected.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);                 // Let the last properties settle
        if (alu_datapath_i.alu_datapath_properties_i.failures == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "bound property failures");
        end
    end

endmodule

// ==== build.f ====
logic/alu_pkg.sv
logic/exec_bus_if.sv
logic/register_file.sv
logic/instr_decoder.sv
logic/cla_block_4bit.sv
logic/carry_look_ahead_32bit.sv
logic/arithmetic_logic_unit.sv
logic/alu_datapath.sv
verification/alu_datapath_properties.sv
verification/alu_datapath_tb.sv
